//--- sources.f
bus_pkg.sv
isa_pkg.sv
cpu_core.sv
bus_strobe_gen.sv
opcode_tracer.sv
cpu_subsys.sv
tb_bus_memory.sv
tb_cpu_subsys.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_cpu_subsys
FILELIST  := sources.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

//--- tb_cpu_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_subsys;

  localparam int worst_instr_cycles = 22;  // M1, two operands, one I/O access, all stretched
  localparam int instr_count = 8;
  localparam int timeout_cycles = 40 * worst_instr_cycles * instr_count;

  logic cpu_bus = 1'b0;
  logic reset = 1'b1;
  logic wait_n;
  logic [7:0] data_in;
  logic [15:0] addr;
  logic [7:0] data_out;
  logic mreq;
  logic iorq;
  logic rd;
  logic wr;
  logic m1;
  logic halt;
  logic req;
  logic opcode_valid;
  logic [31:0] opcode;
  logic [1:0] opcode_len;
  logic [15:0] opcode_pc;

  string names [6];
  int errors [6];
  logic [31:0] exp_word [7];  // trace records of the program where the last also covers HALT
  logic [1:0]  exp_len [7];
  logic [15:0] exp_pc [7];
  int rst_cycles = 0;
  int trace_k = 0;
  int req_count = 0;
  int halt_fetches = 0;
  int m1_starts = 0;  // instructions begun before HALT
  logic first_seen = 1'b0;
  logic req_q = 1'b0;
  logic m1_prev = 1'b0;
  int total;

  always #5 cpu_bus = ~cpu_bus;

  cpu_subsys #(.io_wait(1'b1), .t2_write(1'b0)) dut0 (
    .cpu_bus(cpu_bus), .reset(reset), .wait_n(wait_n), .data_in(data_in),
    .addr(addr), .data_out(data_out), .mreq(mreq), .iorq(iorq), .rd(rd), .wr(wr),
    .m1(m1), .halt(halt), .req(req), .opcode(opcode), .opcode_len(opcode_len),
    .opcode_pc(opcode_pc), .opcode_valid(opcode_valid)
  );

  tb_bus_memory mem0 (
    .cpu_bus(cpu_bus), .addr(addr), .data_out(data_out), .mreq(mreq), .iorq(iorq),
    .rd(rd), .wr(wr), .data_in(data_in), .wait_n(wait_n)
  );

  task automatic value_error(input int t, input logic [31:0] exp, input logic [31:0] act);
    $display("Error: %s expected %h actual %h", names[t], exp, act);
    errors[t]++;
  endtask

  task automatic plain_error(input int t, input string what);
    $display("%s: %s", names[t], what);
    errors[t]++;
  endtask

  task automatic test_done(input int t);
    $display("test %s %s", names[t], (errors[t] == 0) ? "passed" : "failed");
  endtask

  // strobes are registered on the falling edge and are stable here
  always @(posedge cpu_bus)
  begin
    if (reset)
    begin
      rst_cycles++;
      if (rst_cycles >= 2)
        assert (!mreq && !iorq && !rd && !wr && !req && !m1 && !halt && !opcode_valid)
          else plain_error(0, "a strobe or status output is active during reset");
    end
    else
    begin
      if (!first_seen)
        assert (!halt && !opcode_valid) else plain_error(0, "status active before first fetch");
      if (!first_seen && rd && mreq)
      begin
        first_seen = 1'b1;
        assert (addr == 16'h0000) else value_error(0, 32'h0, 32'(addr));
        test_done(0);
      end
      if (iorq)
        assert (!mreq) else plain_error(2, "mreq is high during an I/O access");
      if (iorq && wr)
      begin
        assert (addr[7:0] == 8'h10) else value_error(2, 32'h10, 32'(addr[7:0]));
        assert (data_out == 8'h5a) else value_error(1, 32'h5a, 32'(data_out));  // A after reload
      end
      if (req)
      begin
        req_count++;
        assert (mreq || iorq) else plain_error(3, "req is high with no request strobe");
        assert (!req_q) else plain_error(3, "req stays high for more than one edge");
        assert (req_count == int'(mem0.access_count))
          else value_error(3, 32'(mem0.access_count), 32'(req_count));
      end
      // every instruction begins with a rising m1 while its own address is on the bus
      if (m1 && !m1_prev)
      begin
        if (halt)
          halt_fetches++;  // each pass of the HALT loop is a fresh opcode fetch
        else if (m1_starts < 7)
        begin
          assert (addr == exp_pc[m1_starts])
            else value_error(4, 32'(exp_pc[m1_starts]), 32'(addr));
          m1_starts++;
        end
        else
          plain_error(4, "m1 rose more often than the program has instructions");
      end
      if (halt && rd && mreq)
        assert (addr == 16'h0020) else value_error(5, 32'h20, 32'(addr));
      if (halt)
        assert (!wr) else plain_error(5, "a write happened after HALT");
    end
    req_q = req;
    m1_prev = m1;
  end

  // tracer outputs change on the rising edge, so sample them half a cycle later
  always @(negedge cpu_bus)
  begin
    int k;
    k = (trace_k > 6) ? 6 : trace_k;
    if (!reset && opcode_valid)
    begin
      assert (opcode == exp_word[k]) else value_error(4, exp_word[k], opcode);
      assert (opcode_len == exp_len[k]) else value_error(4, 32'(exp_len[k]), 32'(opcode_len));
      assert (opcode_pc == exp_pc[k]) else value_error(4, 32'(exp_pc[k]), 32'(opcode_pc));
      trace_k++;
    end
  end

  initial
  begin
    repeat (timeout_cycles) @(posedge cpu_bus);
    $display("watchdog: the program did not reach HALT within %0d cycles", timeout_cycles);
    $display(">>> FAIL");
    $finish;
  end

  initial
  begin
    names = '{"reset", "mem_write_read", "io_cycle", "wait_req", "opcode_trace", "halt"};
    errors = '{0, 0, 0, 0, 0, 0};
    exp_word = '{32'h3e5a0000, 32'h32008000, 32'h3a008000, 32'hd3100000,
                 32'h3ec30000, 32'hc3200000, 32'h76000000};
    exp_len = '{2'd1, 2'd2, 2'd2, 2'd1, 2'd1, 2'd2, 2'd0};
    exp_pc = '{16'h0000, 16'h0002, 16'h0005, 16'h0008, 16'h000a, 16'h000c, 16'h0020};
    repeat (16) @(posedge cpu_bus);
    load_program();
    @(negedge cpu_bus);
    reset = 1'b0;
    while (trace_k < 9)  // a few HALT loop records after the program
      @(posedge cpu_bus);
    assert (mem0.wr_count == 1) else value_error(1, 32'd1, 32'(mem0.wr_count));
    assert (mem0.wr_addr[0] == 16'h8000) else value_error(1, 32'h8000, 32'(mem0.wr_addr[0]));
    assert (mem0.wr_data[0] == 8'h5a) else value_error(1, 32'h5a, 32'(mem0.wr_data[0]));
    test_done(1);
    assert (mem0.io_count == 1) else value_error(2, 32'd1, 32'(mem0.io_count));
    assert (mem0.io_port[0] == 8'h10) else value_error(2, 32'h10, 32'(mem0.io_port[0]));
    assert (mem0.io_data[0] == 8'h5a) else value_error(2, 32'h5a, 32'(mem0.io_data[0]));
    test_done(2);
    assert (mem0.wait_count > 0) else plain_error(3, "no access was stretched by wait_n");
    test_done(3);
    test_done(4);
    assert (halt_fetches >= 2) else plain_error(5, "the HALT loop did not repeat its fetch");
    test_done(5);
    total = 0;
    foreach (errors[i])
      total += errors[i];
    $display("tests 6, errors %0d, req pulses %0d, trace records %0d",
             total, req_count, trace_k);
    if (total == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  // LD A,5A; LD (8000),A; LD A,(8000); OUT (10),A; LD A,C3; JP 0020; HALT
  task automatic load_program();
    logic [7:0] prog [15];
    prog = '{8'h3e, 8'h5a, 8'h32, 8'h00, 8'h80, 8'h3a, 8'h00, 8'h80,
             8'hd3, 8'h10, 8'h3e, 8'hc3, 8'hc3, 8'h20, 8'h00};
    for (int i = 0; i < 15; i++)
      mem0.mem[i] = prog[i];
    mem0.mem[16'h0020] = 8'h76;
  endtask

endmodule

`default_nettype wire

//--- tb_bus_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bus_memory (
  input  wire        cpu_bus,
  input  wire [15:0] addr,
  input  wire [7:0]  data_out,
  input  wire        mreq,
  input  wire        iorq,
  input  wire        rd,
  input  wire        wr,
  output logic [7:0] data_in,
  output logic       wait_n
);

  logic [7:0]  mem [65536];
  logic [15:0] wr_addr [8];  // memory write log
  logic [7:0]  wr_data [8];
  logic [7:0]  io_port [8];  // I/O write log, low address byte and data
  logic [7:0]  io_data [8];
  int unsigned wr_count;
  int unsigned io_count;
  int unsigned access_count;  // every rd or wr assertion counts once
  int unsigned wait_count;    // reads that got at least one wait state
  int unsigned stall;         // wait states left for the current read
  logic        rd_q;
  logic        wr_q;
  logic        wr_io;
  logic [15:0] wr_addr_q;
  logic [7:0]  wr_data_q;

  initial
  begin
    void'($urandom(96));  // one seed for the whole run
    for (int i = 0; i < 65536; i++)
      mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5c;  // fill depends on both address bytes
    data_in = 8'hff;
    wait_n  = 1'b1;
    rd_q = 1'b0;
    wr_q = 1'b0;
    wr_io = 1'b0;
    wr_addr_q = '0;
    wr_data_q = '0;
    stall = 0;
    wr_count = 0;
    io_count = 0;
    access_count = 0;
    wait_count = 0;
  end

  // strobes move on the falling edge, so look at them just after it
  always @(negedge cpu_bus)
  begin
    #1;
    data_in <= (rd && mreq) ? mem[addr] : 8'hff;
    if (rd && !rd_q)
    begin
      access_count++;
      stall = $urandom % 3;  // 0 to 2 wait states, T2 gets stretched
      if (stall != 0)
        wait_count++;
    end
    else if (stall != 0)
      stall--;
    wait_n <= (stall == 0);
    if (wr && !wr_q)
    begin
      access_count++;
      wr_io = iorq;  // address and data still hold for this access
      wr_addr_q = addr;
      wr_data_q = data_out;
    end
    if (!wr && wr_q)  // write lands when wr drops
    begin
      if (wr_io && io_count < 8)
      begin
        io_port[io_count] = wr_addr_q[7:0];
        io_data[io_count] = wr_data_q;
        io_count++;
      end
      else if (!wr_io && wr_count < 8)
      begin
        mem[wr_addr_q] = wr_data_q;
        wr_addr[wr_count] = wr_addr_q;
        wr_data[wr_count] = wr_data_q;
        wr_count++;
      end
    end
    rd_q = rd;
    wr_q = wr;
  end

endmodule

`default_nettype wire

//--- cpu_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_subsys #(
  parameter bit io_wait  = 1'b1,  // extra automatic T2 on I/O cycles
  parameter bit t2_write = 1'b0   // wr from T2 instead of T3
) (
  input  wire                  cpu_bus,
  input  wire                  reset,
  input  wire                  wait_n,
  input  wire bus_pkg::data_t  data_in,
  output bus_pkg::addr_t       addr,
  output bus_pkg::data_t       data_out,
  output logic                 mreq,
  output logic                 iorq,
  output logic                 rd,
  output logic                 wr,
  output logic                 m1,
  output logic                 halt,
  output logic                 req,
  output isa_pkg::trace_word_t opcode,
  output isa_pkg::op_len_t     opcode_len,
  output bus_pkg::addr_t       opcode_pc,
  output logic                 opcode_valid
);

  import bus_pkg::*;

  mcycle_t mcycle;
  tstate_t tstate;
  addr_t   pc;
  logic    io_cycle;  // level from the core, the pin is the registered strobe
  logic    no_read;
  logic    write;
  logic    intcycle_n;
  logic    fetch;
  logic    data_valid;

  cpu_core #(.io_wait(io_wait)) core0 (
    .cpu_bus(cpu_bus), .reset(reset), .wait_n(wait_n), .data_in(data_in),
    .addr(addr), .data_out(data_out), .mcycle(mcycle), .tstate(tstate),
    .m1(m1), .iorq(io_cycle), .no_read(no_read), .write(write),
    .intcycle_n(intcycle_n), .halt(halt), .fetch(fetch),
    .data_valid(data_valid), .pc(pc)
  );

  bus_strobe_gen #(.t2_write(t2_write)) strobe0 (
    .cpu_bus(cpu_bus), .reset(reset), .mcycle(mcycle), .tstate(tstate),
    .m1(m1), .iorq(io_cycle), .no_read(no_read), .write(write),
    .intcycle_n(intcycle_n), .wait_n(wait_n),
    .mreq(mreq), .iorq_s(iorq), .rd(rd), .wr(wr), .req(req)
  );

  opcode_tracer tracer0 (
    .cpu_bus(cpu_bus), .reset(reset), .data_in(data_in),
    .data_valid(data_valid), .fetch(fetch), .m1(m1), .pc(pc),
    .opcode(opcode), .opcode_len(opcode_len), .opcode_pc(opcode_pc),
    .opcode_valid(opcode_valid)
  );

endmodule

`default_nettype wire

//--- opcode_tracer.sv
`timescale 1ns/1ps
`default_nettype none

module opcode_tracer (
  input  wire                  cpu_bus,
  input  wire                  reset,
  input  wire bus_pkg::data_t  data_in,
  input  wire                  data_valid,
  input  wire                  fetch,
  input  wire                  m1,
  input  wire bus_pkg::addr_t  pc,
  output isa_pkg::trace_word_t opcode,
  output isa_pkg::op_len_t     opcode_len,
  output bus_pkg::addr_t       opcode_pc,
  output logic                 opcode_valid
);

  import bus_pkg::*;
  import isa_pkg::*;

  data_t   slot [4];  // bytes of the instruction being fetched
  op_len_t idx;       // next free slot, equal to the byte count so far
  addr_t   start_pc;  // address of the instruction being fetched
  logic    m1_q;
  logic    m1_rise;
  logic    started;   // at least one instruction has begun since reset

  // m1 rises at T1 of every opcode fetch, including each HALT loop fetch
  assign m1_rise = m1 && !m1_q;

  always_ff @(posedge cpu_bus)
  begin
    if (reset)
    begin
      m1_q         <= 1'b0;
      started      <= 1'b0;
      opcode_valid <= 1'b0;
      idx          <= '0;
    end
    else
    begin
      m1_q <= m1;
      if (m1_rise)
      begin
        opcode_valid <= started;  // the first rise after reset has nothing to report
        started      <= 1'b1;
        idx          <= '0;
      end
      else
      begin
        opcode_valid <= 1'b0;
        if (data_valid && fetch)
          idx <= idx + op_len_t'(1);
      end
    end
  end

  // byte slots and the published record
  always_ff @(posedge cpu_bus)
  begin
    if (m1_rise)
    begin
      opcode     <= {slot[0], slot[1], slot[2], slot[3]};
      opcode_len <= idx - op_len_t'(1);
      opcode_pc  <= start_pc;
      start_pc   <= pc;  // pc still points at the new opcode during T1
      slot[0]    <= '0;
      slot[1]    <= '0;
      slot[2]    <= '0;
      slot[3]    <= '0;
    end
    else if (data_valid && fetch)
      slot[idx] <= data_in;  // data reads of loads never land here
  end

endmodule

`default_nettype wire

//--- bus_strobe_gen.sv
`timescale 1ns/1ps
`default_nettype none

module bus_strobe_gen #(
  parameter bit t2_write = 1'b0  // 1 starts wr in T2 instead of T3
) (
  input  wire                   cpu_bus,
  input  wire                   reset,
  input  wire bus_pkg::mcycle_t mcycle,
  input  wire bus_pkg::tstate_t tstate,
  input  wire                   m1,
  input  wire                   iorq,
  input  wire                   no_read,
  input  wire                   write,
  input  wire                   intcycle_n,
  input  wire                   wait_n,
  output logic                  mreq,
  output logic                  iorq_s,
  output logic                  rd,
  output logic                  wr,
  output logic                  req
);

  logic nxt_mreq;
  logic nxt_iorq;
  logic nxt_rd;
  logic nxt_wr;
  logic ack;  // the current access has already been announced on req

  // strobe values for the next half clock, from the M-cycle and T-state
  always_comb
  begin
    nxt_mreq = 1'b0;
    nxt_iorq = 1'b0;
    nxt_rd   = 1'b0;
    nxt_wr   = 1'b0;
    if (mcycle[0])
    begin
      if (m1 && (tstate[1] || tstate[2]))  // opcode read in T2 and T3
      begin
        nxt_rd   = intcycle_n;
        nxt_mreq = intcycle_n;
        nxt_iorq = !intcycle_n;  // an acknowledge cycle would use iorq here
      end
    end
    else
    begin
      if ((tstate[1] || tstate[2]) && !no_read && !write)
      begin
        nxt_rd   = 1'b1;
        nxt_iorq = iorq;
        nxt_mreq = !iorq;
      end
      if (write && (t2_write ? (tstate[1] || (tstate[2] && !wait_n)) : tstate[2]))
      begin
        nxt_wr   = 1'b1;
        nxt_iorq = iorq;
        nxt_mreq = !iorq;
      end
    end
  end

  // registered on the falling edge so that wait_n stays a plain synchronous input
  always_ff @(negedge cpu_bus)
  begin
    if (reset)
    begin
      mreq   <= 1'b0;
      iorq_s <= 1'b0;
      rd     <= 1'b0;
      wr     <= 1'b0;
    end
    else
    begin
      mreq   <= nxt_mreq;
      iorq_s <= nxt_iorq;
      rd     <= nxt_rd;
      wr     <= nxt_wr;
    end
  end

  // ack closes req after one rising edge and reopens once the request strobes drop
  always_ff @(posedge cpu_bus)
  begin
    if (reset)
      ack <= 1'b0;
    else if (!mreq && !iorq_s)
      ack <= 1'b0;
    else if (req)
      ack <= 1'b1;
  end

  assign req = (mreq || iorq_s) && (rd || wr) && !ack;

endmodule

`default_nettype wire

//--- cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
  parameter bit io_wait = 1'b1  // 1 gives I/O cycles one automatic extra T2
) (
  input  wire              cpu_bus,
  input  wire              reset,
  input  wire              wait_n,
  input  wire bus_pkg::data_t data_in,
  output bus_pkg::addr_t   addr,
  output bus_pkg::data_t   data_out,
  output bus_pkg::mcycle_t mcycle,
  output bus_pkg::tstate_t tstate,
  output logic             m1,
  output logic             iorq,
  output logic             no_read,
  output logic             write,
  output logic             intcycle_n,
  output logic             halt,
  output logic             fetch,
  output logic             data_valid,
  output bus_pkg::addr_t   pc
);

  import bus_pkg::*;
  import isa_pkg::*;

  exec_state_t state;      // machine cycle in progress
  exec_state_t nxt_state;  // machine cycle that follows the current one
  data_t ir;               // opcode of the running instruction
  data_t a;                // accumulator
  data_t tgt_lo;           // n, or the low byte of nn
  data_t tgt_hi;           // high byte of nn
  logic  io_ext;           // the automatic I/O wait state has been spent
  logic  io_hold;
  logic  m1_cycle;
  logic  m_end;

  // the HALT loop runs opcode fetches too, so it counts as M1
  assign m1_cycle = (state == isa_pkg::fetch) || (state == halted);

  // M1 ends after T4 and every other cycle ends after T3
  assign m_end = m1_cycle ? tstate[3] : tstate[2];

  assign io_hold = io_wait && iorq && !io_ext;  // first pass through T2 of an I/O cycle

  // bytes are only taken when the memory is not stretching the cycle
  assign data_valid = tstate[2] && wait_n;

  // decode runs in T4 of M1 on the latched opcode and picks the next cycles
  always_comb
  begin
    nxt_state = isa_pkg::fetch;
    case (state)
      isa_pkg::fetch:
      begin
        case (ir)
          op_halt:
            nxt_state = halted;
          op_ld_a_n, op_ld_nn_a, op_ld_a_nn, op_out_n_a, op_jp_nn:
            nxt_state = operand_lo;
          default:
            nxt_state = isa_pkg::fetch;  // NOP, and unknown opcodes act like it
        endcase
      end
      operand_lo:
      begin
        if (ir == op_out_n_a)
          nxt_state = io_write;
        else if (ir != op_ld_a_n)
          nxt_state = operand_hi;  // all the nn forms need a second byte
      end
      operand_hi:
      begin
        if (ir == op_ld_nn_a)
          nxt_state = mem_write;
        else if (ir == op_ld_a_nn)
          nxt_state = mem_read;  // JP is done once the target is loaded
      end
      halted:
        nxt_state = halted;  // only reset leaves HALT
      default:
        nxt_state = isa_pkg::fetch;  // data cycles end the instruction
    endcase
  end

  // T-state sequencer, M-cycle advance and program counter
  always_ff @(posedge cpu_bus)
  begin
    if (reset)
    begin
      state  <= isa_pkg::fetch;
      tstate <= ts_t1;
      io_ext <= 1'b0;
      pc     <= '0;
    end
    else
    begin
      if (tstate[0])
        tstate <= ts_t2;
      else if (tstate[1])
      begin
        if (io_hold)
          io_ext <= 1'b1;  // stay in T2 one more clock before looking at wait_n
        else if (wait_n)
          tstate <= ts_t3;
      end
      else if (m_end)
      begin
        tstate <= ts_t1;
        state  <= nxt_state;
        io_ext <= 1'b0;
      end
      else
        tstate <= ts_t4;

      if (data_valid)
      begin
        case (state)
          isa_pkg::fetch:
            if (data_in != op_halt)
              pc <= pc + addr_t'(1);  // HALT keeps its own address for the loop
          operand_lo:
            pc <= pc + addr_t'(1);
          operand_hi:
            if (ir == op_jp_nn)
              pc <= {data_in, tgt_lo};
            else
              pc <= pc + addr_t'(1);
          default:
            pc <= pc;
        endcase
      end
    end
  end

  // opcode, operand and accumulator loads
  always_ff @(posedge cpu_bus)
  begin
    if (data_valid)
    begin
      case (state)
        isa_pkg::fetch:
          ir <= data_in;
        operand_lo:
        begin
          tgt_lo <= data_in;
          if (ir == op_ld_a_n)
            a <= data_in;
        end
        operand_hi:
          tgt_hi <= data_in;
        mem_read:
          a <= data_in;
        default:
          ir <= ir;
      endcase
    end
  end

  // OUT puts n on the low address byte and A on the high one, as a Z80 does
  always_comb
  begin
    case (state)
      mem_read, mem_write:
        addr = {tgt_hi, tgt_lo};
      io_write:
        addr = {a, tgt_lo};
      default:
        addr = pc;
    endcase
  end

  assign data_out = a;  // only stores and OUT write, and both write A

  assign mcycle = m1_cycle ? mc_m1 : (state == operand_lo) ? mc_m2 : mc_m3;

  // m1 drops in T4 and stays low in reset, so every instruction starts with a rising edge
  assign m1 = m1_cycle && !tstate[3] && !reset;

  assign iorq    = (state == io_write);
  assign write   = (state == mem_write) || (state == io_write);
  assign no_read = write;  // a write cycle never reads the bus as well
  assign halt    = (state == halted);

  assign fetch = m1_cycle || (state == operand_lo) || (state == operand_hi);

  assign intcycle_n = 1'b1;  // there are no interrupt acknowledge cycles

endmodule

`default_nettype wire

//--- isa_pkg.sv
`default_nettype none

package isa_pkg;

  // opcodes of the supported subset, Z80 encodings
  localparam bus_pkg::data_t op_nop     = 8'h00;
  localparam bus_pkg::data_t op_ld_a_n  = 8'h3e;  // A <= n
  localparam bus_pkg::data_t op_ld_nn_a = 8'h32;  // (nn) <= A
  localparam bus_pkg::data_t op_ld_a_nn = 8'h3a;  // A <= (nn)
  localparam bus_pkg::data_t op_out_n_a = 8'hd3;  // port n <= A
  localparam bus_pkg::data_t op_jp_nn   = 8'hc3;
  localparam bus_pkg::data_t op_halt    = 8'h76;

  // one state per machine cycle the core can run
  typedef enum logic [2:0] {
    fetch,       // M1, opcode read
    operand_lo,  // first operand byte, n or the low half of nn
    operand_hi,  // high half of nn
    mem_read,
    mem_write,
    io_write,
    halted       // M1 cycles repeated at the HALT address
  } exec_state_t;

  // number of bytes in an instruction, minus one
  typedef logic [1:0] op_len_t;

  // four bytes, the first fetched byte sits in bits 31:24
  typedef logic [31:0] trace_word_t;

endpackage

`default_nettype wire

//--- bus_pkg.sv
`default_nettype none

package bus_pkg;

  // 64k address space, the program counter has the same width
  typedef logic [15:0] addr_t;

  typedef logic [7:0] data_t;  // one byte on the data bus

  // one-hot T-state, bit 0 is T1 and bit 3 is T4
  typedef logic [3:0] tstate_t;

  // one-hot M-cycle, bit 0 is the opcode fetch (M1)
  typedef logic [2:0] mcycle_t;

  localparam tstate_t ts_t1 = 4'b0001;
  localparam tstate_t ts_t2 = 4'b0010;  // wait states repeat this one
  localparam tstate_t ts_t3 = 4'b0100;
  localparam tstate_t ts_t4 = 4'b1000;  // only the opcode fetch reaches T4

  localparam mcycle_t mc_m1 = 3'b001;
  localparam mcycle_t mc_m2 = 3'b010;
  // every access after the second byte is reported as M3
  localparam mcycle_t mc_m3 = 3'b100;

endpackage

`default_nettype wire
